// File: common/xr_params.svh
/*
 * XR memory-map sizes shared by RTL and testbench.
 * Region widths must add up to XR_ADDR_W together with the region field.
 */
`ifndef XR_PARAMS_SVH
`define XR_PARAMS_SVH

// data and full address width
`define XR_DATA_W   16
`define XR_ADDR_W   16

// top address bits select the region
`define XR_REGION_W 2

// index widths inside each region
`define XR_REG_W    4
`define XR_COLOR_W  8
`define XR_TILE_W   10

// read-only value of config register 0
`define XR_ID_VALUE 16'hC0DE

`endif

// File: common/xr_map_pkg.sv
/*
 * XR memory-map types. The region field is the top two address bits
 * in every view; bits between region and index are ignored.
 */
`default_nettype none

`include "xr_params.svh"

package xr_map_pkg;

    typedef logic [`XR_DATA_W-1:0] word_t;

    typedef enum logic [`XR_REGION_W-1:0] {
        REGS  = 2'd0,
        COLOR = 2'd1,
        TILE  = 2'd2,
        NONE  = 2'd3
    } xr_region_e;

    // config register view
    typedef struct packed {
        xr_region_e                                         region;
        logic [`XR_ADDR_W-`XR_REGION_W-`XR_REG_W-1:0]       unused;
        logic [`XR_REG_W-1:0]                               idx;
    } xr_reg_addr_t;

    // colour lookup view
    typedef struct packed {
        xr_region_e                                         region;
        logic [`XR_ADDR_W-`XR_REGION_W-`XR_COLOR_W-1:0]     unused;
        logic [`XR_COLOR_W-1:0]                             idx;
    } xr_color_addr_t;

    // tile memory view
    typedef struct packed {
        xr_region_e                                         region;
        logic [`XR_ADDR_W-`XR_REGION_W-`XR_TILE_W-1:0]      unused;
        logic [`XR_TILE_W-1:0]                              idx;
    } xr_tile_addr_t;

    // one address word, decoded per region
    typedef union packed {
        xr_reg_addr_t   regs;
        xr_color_addr_t color;
        xr_tile_addr_t  tile;
    } xr_addr_u;

endpackage

`default_nettype wire

// File: common/xr_bus_pkg.sv
/*
 * Client and register bus structs of the XR arbiter.
 * Host and copper hold every field stable while sel is high.
 */
`default_nettype none

`include "xr_params.svh"

package xr_bus_pkg;

    // host register port, read and write
    typedef struct packed {
        logic                   sel;
        logic                   wr;
        xr_map_pkg::xr_addr_u   addr;
        xr_map_pkg::word_t      data;
    } xr_host_req_t;

    // copper port, write only
    typedef struct packed {
        logic                   sel;
        xr_map_pkg::xr_addr_u   addr;
        xr_map_pkg::word_t      data;
    } xr_copp_req_t;

    // video generator reads, one per memory per clock
    typedef struct packed {
        logic                   color_sel;
        logic [`XR_COLOR_W-1:0] color_addr;
        logic                   tile_sel;
        logic [`XR_TILE_W-1:0]  tile_addr;
    } vgen_rd_t;

    // arbiter to config register file
    typedef struct packed {
        logic                   wr;
        logic [`XR_REG_W-1:0]   idx;
        xr_map_pkg::word_t      data;
    } xreg_bus_t;

endpackage

`default_nettype wire

// File: hdl/xr_ram.sv
/*
 * Single-clock RAM, one write port and one registered read port.
 * Read during write to the same address returns the old word.
 * Contents start at zero; there is no reset of the array.
 */
`default_nettype none
`timescale 1ns/10ps

`include "xr_params.svh"

module xr_ram #(
    parameter int ADDR_W = `XR_COLOR_W
) (
    input  wire logic               clk,
    input  wire logic               rst_n_i,
    input  wire logic               wr_en_i,
    input  wire logic [ADDR_W-1:0]  wr_addr_i,
    input  wire xr_map_pkg::word_t  wr_data_i,
    input  wire logic [ADDR_W-1:0]  rd_addr_i,
    output      xr_map_pkg::word_t  rd_data_o
);

    xr_map_pkg::word_t mem [2**ADDR_W];

    // zero fill, also picked up as block RAM init
    initial begin
        for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

    // an X address would corrupt an unknown word
    wr_addr_known_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        wr_en_i |-> !$isunknown(wr_addr_i));

endmodule

`default_nettype wire

// File: hdl/xr_config_regs.sv
/*
 * 16 x 16-bit configuration registers on the XR register bus.
 * Register 0 is a read-only ID; writes to it are dropped.
 * Read data follows the bus index combinationally.
 */
`default_nettype none
`timescale 1ns/10ps

`include "xr_params.svh"

module xr_config_regs (
    input  wire logic                   clk,
    input  wire logic                   rst_n_i,
    input  wire xr_bus_pkg::xreg_bus_t  xreg_i,
    output      xr_map_pkg::word_t      xreg_data_o
);

    localparam int NUM_REGS = 2**`XR_REG_W;

    // entry 0 is the ID and has no storage
    xr_map_pkg::word_t regs_q [1:NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (xreg_i.wr && xreg_i.idx != '0) begin
            regs_q[xreg_i.idx] <= xreg_i.data;
        end
    end

    always_comb begin
        if (xreg_i.idx == '0) begin
            xreg_data_o = `XR_ID_VALUE;
        end else begin
            xreg_data_o = regs_q[xreg_i.idx];
        end
    end

endmodule

`default_nettype wire

// File: hdl/xr_mem_arb.sv
/*
 * XR arbiter: copper writes win over host, video reads win over host reads.
 * Acks are single-cycle pulses; a sel seen while its ack is high is ignored.
 * Any host access waits while copper sel is high.
 */
`default_nettype none
`timescale 1ns/10ps

`include "xr_params.svh"

module xr_mem_arb (
    input  wire logic                       clk,
    input  wire logic                       rst_n_i,
    input  wire xr_bus_pkg::xr_host_req_t   host_i,
    output      logic                       xr_ack_o,
    output      xr_map_pkg::word_t          xr_data_o,
    input  wire xr_bus_pkg::xr_copp_req_t   copp_i,
    output      logic                       copp_ack_o,
    input  wire xr_bus_pkg::vgen_rd_t       vgen_i,
    output      xr_map_pkg::word_t          color_data_o,
    output      xr_map_pkg::word_t          tile_data_o,
    output      xr_bus_pkg::xreg_bus_t      xreg_o,
    input  wire xr_map_pkg::word_t          xreg_data_i
);

    xr_map_pkg::xr_region_e     host_region;
    xr_map_pkg::xr_region_e     rd_region_q;
    xr_map_pkg::xr_addr_u       wr_addr;
    xr_map_pkg::word_t          wr_data;
    xr_map_pkg::word_t          reg_rd_q;
    xr_map_pkg::word_t          color_rd_data;
    xr_map_pkg::word_t          tile_rd_data;
    logic                       copp_wr;
    logic                       host_go;
    logic                       host_wr;
    logic                       host_rd;
    logic                       wr_any;
    logic                       color_wr_en;
    logic                       tile_wr_en;
    logic [`XR_COLOR_W-1:0]     color_rd_addr;
    logic [`XR_TILE_W-1:0]      tile_rd_addr;

    assign host_region = host_i.addr.regs.region;

    // copper first, host only when copper is idle and no ack is showing
    assign copp_wr = copp_i.sel & ~copp_ack_o;
    assign host_go = host_i.sel & ~xr_ack_o & ~copp_i.sel;
    assign host_wr = host_go & host_i.wr;

    // reads to memory wait for a cycle without the video select
    always_comb begin
        host_rd = 1'b0;
        if (host_go && !host_i.wr) begin
            case (host_region)
                xr_map_pkg::COLOR: host_rd = ~vgen_i.color_sel;
                xr_map_pkg::TILE:  host_rd = ~vgen_i.tile_sel;
                default:           host_rd = 1'b1;
            endcase
        end
    end

    // write source mux
    assign wr_any  = copp_wr | host_wr;
    assign wr_addr = copp_wr ? copp_i.addr : host_i.addr;
    assign wr_data = copp_wr ? copp_i.data : host_i.data;

    // region 3 writes fall through with no enable
    assign color_wr_en = wr_any & (wr_addr.color.region == xr_map_pkg::COLOR);
    assign tile_wr_en  = wr_any & (wr_addr.tile.region == xr_map_pkg::TILE);

    assign xreg_o.wr   = wr_any & (wr_addr.regs.region == xr_map_pkg::REGS);
    assign xreg_o.idx  = wr_addr.regs.idx;
    assign xreg_o.data = wr_data;

    // read port goes to the host only on an issued read
    assign color_rd_addr = (host_rd && host_region == xr_map_pkg::COLOR) ?
                           host_i.addr.color.idx : vgen_i.color_addr;
    assign tile_rd_addr  = (host_rd && host_region == xr_map_pkg::TILE) ?
                           host_i.addr.tile.idx : vgen_i.tile_addr;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            xr_ack_o    <= 1'b0;
            copp_ack_o  <= 1'b0;
            rd_region_q <= xr_map_pkg::REGS;
        end else begin
            xr_ack_o   <= host_wr | host_rd;
            copp_ack_o <= copp_wr;
            if (host_rd) begin
                rd_region_q <= host_region;
            end
        end
    end

    // hold the register word, copper may move the index during the ack
    always_ff @(posedge clk) begin
        if (host_rd && host_region == xr_map_pkg::REGS) begin
            reg_rd_q <= xreg_data_i;
        end
    end

    always_comb begin
        case (rd_region_q)
            xr_map_pkg::REGS:  xr_data_o = reg_rd_q;
            xr_map_pkg::COLOR: xr_data_o = color_rd_data;
            xr_map_pkg::TILE:  xr_data_o = tile_rd_data;
            default:           xr_data_o = '0;
        endcase
    end

    assign color_data_o = color_rd_data;
    assign tile_data_o  = tile_rd_data;

    xr_ram #(
        .ADDR_W     (`XR_COLOR_W)
    ) color_mem_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wr_en_i    (color_wr_en),
        .wr_addr_i  (wr_addr.color.idx),
        .wr_data_i  (wr_data),
        .rd_addr_i  (color_rd_addr),
        .rd_data_o  (color_rd_data)
    );

    xr_ram #(
        .ADDR_W     (`XR_TILE_W)
    ) tile_mem_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wr_en_i    (tile_wr_en),
        .wr_addr_i  (wr_addr.tile.idx),
        .wr_data_i  (wr_data),
        .rd_addr_i  (tile_rd_addr),
        .rd_data_o  (tile_rd_data)
    );

    // acks are pulses, never back to back
    ack_pulse_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        (xr_ack_o |=> !xr_ack_o) and (copp_ack_o |=> !copp_ack_o));

    // copper and host writes never complete in the same cycle
    ack_excl_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        copp_ack_o |-> !(xr_ack_o && $past(host_i.wr)));

endmodule

`default_nettype wire

// File: hdl/xr_subsystem.sv
/*
 * XR subsystem: memory arbiter plus configuration registers.
 * Host, copper and video ports are taken straight from their clients.
 */
`default_nettype none
`timescale 1ns/10ps

module xr_subsystem (
    input  wire logic                       clk,
    input  wire logic                       rst_n_i,
    input  wire xr_bus_pkg::xr_host_req_t   host_i,
    output      logic                       xr_ack_o,
    output      xr_map_pkg::word_t          xr_data_o,
    input  wire xr_bus_pkg::xr_copp_req_t   copp_i,
    output      logic                       copp_ack_o,
    input  wire xr_bus_pkg::vgen_rd_t       vgen_i,
    output      xr_map_pkg::word_t          color_data_o,
    output      xr_map_pkg::word_t          tile_data_o
);

    xr_bus_pkg::xreg_bus_t  xreg_bus;
    xr_map_pkg::word_t      xreg_data;

    xr_mem_arb arb_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .host_i         (host_i),
        .xr_ack_o       (xr_ack_o),
        .xr_data_o      (xr_data_o),
        .copp_i         (copp_i),
        .copp_ack_o     (copp_ack_o),
        .vgen_i         (vgen_i),
        .color_data_o   (color_data_o),
        .tile_data_o    (tile_data_o),
        .xreg_o         (xreg_bus),
        .xreg_data_i    (xreg_data)
    );

    xr_config_regs regs_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .xreg_i         (xreg_bus),
        .xreg_data_o    (xreg_data)
    );

endmodule

`default_nettype wire

// File: dv/xr_subsystem_tb.sv
/*
 * Random testbench for the XR subsystem with the LFSR seeded at 62.
 * Shadow model of registers, colour and tile memory follows every write ack.
 * Inputs change on the falling edge and outputs are sampled there as well.
 */
`default_nettype none
`timescale 1ns/10ps

`include "xr_params.svh"

module xr_subsystem_tb;

    localparam int RESET_CYCLES = 16;
    localparam int N_REG        = 16;
    localparam int N_COLOR      = 16;
    localparam int N_TILE       = 32;
    localparam int N_COPP       = 8;
    localparam int N_HOLD       = 8;
    localparam int N_NONE       = 8;
    localparam int HOLD_MAX     = 5;
    // worst op covers video hold, read issue and ack with some slack
    localparam int OP_LAT       = HOLD_MAX + 4;
    localparam int TOTAL_OPS    = 2 * N_REG + 2 + 2 * N_COLOR + 2 * N_TILE
                                + 6 * N_COPP + 2 * N_HOLD + 5 * N_NONE;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + TOTAL_OPS * OP_LAT + 200;

    logic                       clk;
    logic                       rst_n;
    xr_bus_pkg::xr_host_req_t   host_req;
    xr_bus_pkg::xr_copp_req_t   copp_req;
    xr_bus_pkg::vgen_rd_t       vgen_req;
    logic                       xr_ack;
    logic                       copp_ack;
    xr_map_pkg::word_t          xr_data;
    xr_map_pkg::word_t          color_data;
    xr_map_pkg::word_t          tile_data;

    // shadow state
    xr_map_pkg::word_t reg_model   [2**`XR_REG_W];
    xr_map_pkg::word_t color_model [2**`XR_COLOR_W];
    xr_map_pkg::word_t tile_model  [2**`XR_TILE_W];

    logic [15:0]    lfsr;
    int             cycle_count;
    int             check_count;
    int             err_count;
    int             test_err_base;

    xr_subsystem dut_i (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .host_i         (host_req),
        .xr_ack_o       (xr_ack),
        .xr_data_o      (xr_data),
        .copp_i         (copp_req),
        .copp_ack_o     (copp_ack),
        .vgen_i         (vgen_req),
        .color_data_o   (color_data),
        .tile_data_o    (tile_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[14:0], fb};
        end
        return v;
    endfunction

    // bits between region and index are random and the DUT must ignore them
    function automatic logic [15:0] rand_addr(input xr_map_pkg::xr_region_e region);
        logic [15:0] r;
        r = rand_bits(14);
        return {region, r[13:0]};
    endfunction

    function automatic xr_map_pkg::word_t model_read(input logic [15:0] addr);
        case (xr_map_pkg::xr_region_e'(addr[15:14]))
            xr_map_pkg::REGS:  return reg_model[addr[`XR_REG_W-1:0]];
            xr_map_pkg::COLOR: return color_model[addr[`XR_COLOR_W-1:0]];
            xr_map_pkg::TILE:  return tile_model[addr[`XR_TILE_W-1:0]];
            default:           return '0;
        endcase
    endfunction

    function automatic void model_write(input logic [15:0] addr, input xr_map_pkg::word_t d);
        case (xr_map_pkg::xr_region_e'(addr[15:14]))
            xr_map_pkg::REGS: begin
                // register 0 stays the ID
                if (addr[`XR_REG_W-1:0] != '0) begin
                    reg_model[addr[`XR_REG_W-1:0]] = d;
                end
            end
            xr_map_pkg::COLOR: color_model[addr[`XR_COLOR_W-1:0]] = d;
            xr_map_pkg::TILE:  tile_model[addr[`XR_TILE_W-1:0]] = d;
            default: ;
        endcase
    endfunction

    task automatic check_eq(input string what, input xr_map_pkg::word_t got,
                            input xr_map_pkg::word_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, err_count - test_err_base);
        test_err_base = err_count;
    endtask

    // returns on the falling edge where the ack is seen
    task automatic wait_host_ack(output xr_map_pkg::word_t rdata);
        @(negedge clk);
        while (!xr_ack) begin
            @(negedge clk);
        end
        rdata = xr_data;
        host_req.sel = 1'b0;
    endtask

    task automatic host_access(input logic wr, input logic [15:0] addr,
                               input xr_map_pkg::word_t data,
                               output xr_map_pkg::word_t rdata);
        host_req.sel  = 1'b1;
        host_req.wr   = wr;
        host_req.addr = addr;
        host_req.data = data;
        wait_host_ack(rdata);
        if (wr) begin
            model_write(addr, data);
        end
    endtask

    task automatic host_read_check(input logic [15:0] addr, input string what);
        xr_map_pkg::word_t rd;
        host_access(1'b0, addr, '0, rd);
        check_eq(what, rd, model_read(addr));
    endtask

    // one video read with data expected one cycle after the address
    task automatic video_check(input logic use_tile, input logic [15:0] addr);
        if (use_tile) begin
            vgen_req.tile_sel  = 1'b1;
            vgen_req.tile_addr = addr[`XR_TILE_W-1:0];
        end else begin
            vgen_req.color_sel  = 1'b1;
            vgen_req.color_addr = addr[`XR_COLOR_W-1:0];
        end
        @(negedge clk);
        if (use_tile) begin
            check_eq("tile video read", tile_data, tile_model[addr[`XR_TILE_W-1:0]]);
        end else begin
            check_eq("colour video read", color_data, color_model[addr[`XR_COLOR_W-1:0]]);
        end
        vgen_req.tile_sel  = 1'b0;
        vgen_req.color_sel = 1'b0;
    endtask

    task automatic registers_readback();
        logic [15:0]        addr;
        xr_map_pkg::word_t  rd;
        for (int i = 0; i < N_REG; i++) begin
            addr = rand_addr(xr_map_pkg::REGS);
            if (addr[`XR_REG_W-1:0] == '0) begin
                addr[`XR_REG_W-1:0] = '1;
            end
            host_access(1'b1, addr, rand_bits(16), rd);
            host_read_check(addr, "register read back");
        end
        addr = rand_addr(xr_map_pkg::REGS);
        addr[`XR_REG_W-1:0] = '0;
        host_access(1'b1, addr, rand_bits(16), rd);
        host_access(1'b0, addr, '0, rd);
        check_eq("ID register after write", rd, `XR_ID_VALUE);
        end_test(1, "register write and read back");
    endtask

    task automatic color_video_path();
        logic [15:0]        addr;
        xr_map_pkg::word_t  rd;
        for (int i = 0; i < N_COLOR; i++) begin
            addr = rand_addr(xr_map_pkg::COLOR);
            host_access(1'b1, addr, rand_bits(16), rd);
            video_check(1'b0, addr);
        end
        end_test(2, "colour write seen by video");
    endtask

    task automatic tile_access_mix();
        logic [15:0]        addr;
        logic [15:0]        last;
        logic [15:0]        r;
        xr_map_pkg::word_t  rd;
        last = rand_addr(xr_map_pkg::TILE);
        for (int i = 0; i < N_TILE; i++) begin
            r    = rand_bits(2);
            // reuse the last address half the time so reads hit written words
            addr = r[1] ? last : rand_addr(xr_map_pkg::TILE);
            if (r[0]) begin
                host_access(1'b1, addr, rand_bits(16), rd);
            end else begin
                host_read_check(addr, "tile host read");
            end
            video_check(1'b1, addr);
            last = addr;
        end
        end_test(3, "tile memory host and video access");
    endtask

    task automatic pick_copper_write(output logic [15:0] addr, output xr_map_pkg::word_t d);
        logic [15:0]            r;
        xr_map_pkg::xr_region_e region;
        r = rand_bits(2);
        case (r[1:0])
            2'd0:    region = xr_map_pkg::REGS;
            2'd1:    region = xr_map_pkg::COLOR;
            default: region = xr_map_pkg::TILE;
        endcase
        addr = rand_addr(region);
        d    = rand_bits(16);
    endtask

    // three copper writes back to back against one host write
    task automatic copper_round();
        logic [15:0]        c_addr;
        logic [15:0]        h_addr;
        xr_map_pkg::word_t  c_data;
        xr_map_pkg::word_t  h_data;
        int                 copp_left;
        logic               host_done;
        logic               sel_seen;
        logic               ack_before;
        copp_left = 3;
        host_done = 1'b0;
        ack_before = 1'b0;
        pick_copper_write(c_addr, c_data);
        h_addr = rand_addr(xr_map_pkg::TILE);
        h_data = rand_bits(16);
        copp_req.sel  = 1'b1;
        copp_req.addr = c_addr;
        copp_req.data = c_data;
        host_req.sel  = 1'b1;
        host_req.wr   = 1'b1;
        host_req.addr = h_addr;
        host_req.data = h_data;
        while (copp_left > 0 || !host_done) begin
            @(negedge clk);
            sel_seen = copp_req.sel;
            // a held select is taken the cycle after it is seen, unless the ack was showing
            check_eq("copper ack", 16'(copp_ack), 16'(sel_seen && !ack_before));
            ack_before = copp_ack;
            if (copp_req.sel) begin
                check_eq("host ack while copper holds sel", 16'(xr_ack), 16'h0);
            end
            if (xr_ack) begin
                host_done    = 1'b1;
                host_req.sel = 1'b0;
                model_write(h_addr, h_data);
            end
            if (copp_ack) begin
                model_write(c_addr, c_data);
                copp_left--;
                if (copp_left > 0) begin
                    pick_copper_write(c_addr, c_data);
                    copp_req.addr = c_addr;
                    copp_req.data = c_data;
                end else begin
                    copp_req.sel = 1'b0;
                end
            end
        end
        host_read_check(h_addr, "host write after copper");
        host_read_check(c_addr, "last copper write");
    endtask

    task automatic copper_priority();
        for (int i = 0; i < N_COPP; i++) begin
            copper_round();
        end
        end_test(4, "copper priority over host");
    endtask

    task automatic held_read(input logic use_tile);
        logic [15:0]        addr;
        logic [15:0]        r;
        int                 hold;
        xr_map_pkg::word_t  rd;
        addr = rand_addr(use_tile ? xr_map_pkg::TILE : xr_map_pkg::COLOR);
        host_access(1'b1, addr, rand_bits(16), rd);
        r    = rand_bits(2);
        hold = 2 + int'(r[1:0]);
        vgen_req.tile_sel  = use_tile;
        vgen_req.color_sel = !use_tile;
        host_req.sel  = 1'b1;
        host_req.wr   = 1'b0;
        host_req.addr = addr;
        repeat (hold) begin
            @(negedge clk);
            check_eq("read ack while video holds the memory", 16'(xr_ack), 16'h0);
        end
        vgen_req.tile_sel  = 1'b0;
        vgen_req.color_sel = 1'b0;
        wait_host_ack(rd);
        check_eq("read after video hold", rd, model_read(addr));
    endtask

    task automatic read_holdoff();
        logic [15:0] r;
        for (int i = 0; i < N_HOLD; i++) begin
            r = rand_bits(1);
            held_read(r[0]);
        end
        end_test(5, "host read held off by video");
    endtask

    task automatic unmapped_region();
        logic [15:0]        addr;
        xr_map_pkg::word_t  rd;
        for (int i = 0; i < N_NONE; i++) begin
            addr = rand_addr(xr_map_pkg::NONE);
            host_access(1'b1, addr, rand_bits(16), rd);
            host_access(1'b0, addr, '0, rd);
            check_eq("unmapped read", rd, 16'h0);
            // the same low bits in every mapped region must be untouched
            host_read_check({xr_map_pkg::REGS, addr[13:0]}, "register after unmapped write");
            host_read_check({xr_map_pkg::COLOR, addr[13:0]}, "colour after unmapped write");
            host_read_check({xr_map_pkg::TILE, addr[13:0]}, "tile after unmapped write");
        end
        end_test(6, "unmapped region");
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        host_req      = '0;
        copp_req      = '0;
        vgen_req      = '0;
        lfsr          = 16'd62;
        check_count   = 0;
        err_count     = 0;
        test_err_base = 0;
        for (int i = 0; i < 2**`XR_REG_W; i++) begin
            reg_model[i] = '0;
        end
        reg_model[0] = `XR_ID_VALUE;
        for (int i = 0; i < 2**`XR_COLOR_W; i++) begin
            color_model[i] = '0;
        end
        for (int i = 0; i < 2**`XR_TILE_W; i++) begin
            tile_model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        registers_readback();
        color_video_path();
        tile_access_mix();
        copper_priority();
        read_holdoff();
        unmapped_region();
        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: xr_subsystem.f
+incdir+common
common/xr_map_pkg.sv
common/xr_bus_pkg.sv
hdl/xr_ram.sv
hdl/xr_config_regs.sv
hdl/xr_mem_arb.sv
hdl/xr_subsystem.sv
dv/xr_subsystem_tb.sv

// File: Makefile
# Verilator build and run for the XR subsystem

VERILATOR ?= verilator
FILELIST  ?= xr_subsystem.f
RTL_TOP   ?= xr_subsystem
TB_TOP    ?= xr_subsystem_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

FAIL_MSG  := TESTBENCH FAILED
PASS_MSG  := TESTBENCH PASSED

SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
SIM_BIN   := $(BUILD_DIR)/$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
